/* verilog/alarm_pkg.sv */
//####################################################################
// widths and sequencer types for the puzzle alarm top level
// target is 7 bits and is compared zero-extended to one operand word
//####################################################################
`default_nettype none

package alarm_pkg;

    localparam int unsigned operand_w   = 8;
    localparam int unsigned target_w    = 7;
    localparam int unsigned num_puzzles = 2;   // ratio then product

    // user operand and ALU word, all arithmetic modulo 256
    typedef logic [operand_w-1:0] operand_t;

    // puzzle target, e.g. the running timer value
    typedef logic [target_w-1:0] target_t;

    // alarm sequencer states
    typedef enum logic [2:0] {
        seq_idle          = 3'd0,
        seq_ringing       = 3'd1,
        seq_solve_ratio   = 3'd2,
        seq_solve_product = 3'd3,
        seq_awake         = 3'd4
    } seq_state_t;

    // status word seen outside the top
    typedef struct packed {
        logic                   ringing;   // alarm sounds
        logic                   awake;     // both puzzles solved
        logic [num_puzzles-1:0] active;    // one-hot, puzzle enabled
    } alarm_status_t;

endpackage : alarm_pkg

`default_nettype wire

/* verilog/equation_pkg.sv */
//####################################################################
// types shared by the equation unit FSM and its datapath
// one micro-operation is issued per cycle, idle means no register loads
//####################################################################
`default_nettype none

package equation_pkg;

    // which formula a unit evaluates
    typedef enum logic {
        ratio_sum   = 1'b0,   // (x/z)*(x/z) + y/z
        product_sum = 1'b1    // x*x*z + x*y
    } equation_kind_t;

    // ALU operations, only the ones the formulas need
    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_mul = 2'd1,
        alu_div = 2'd2    // truncating, x/0 gives 0
    } alu_op_t;

    // operand register select for both ALU inputs
    typedef enum logic [1:0] {
        sel_x = 2'd0,
        sel_y = 2'd1,
        sel_z = 2'd2
    } reg_sel_t;

    // control word from the unit FSM to the datapath
    typedef struct packed {
        logic     load_x;
        logic     load_y;
        logic     load_z;     // z only ever loads from data_in
        logic     from_alu;   // x/y take the ALU result instead of data_in
        reg_sel_t sel_a;
        reg_sel_t sel_b;
        alu_op_t  op;
        logic     load_r;     // result register, always from the ALU
        logic     clear;      // zero x, y, z, r and sample target
    } eq_uop_t;

    // no loads, no clear
    localparam eq_uop_t uop_idle = '0;

endpackage : equation_pkg

`default_nettype wire

/* verilog/equation_datapath.sv */
//####################################################################
// operand, target and result registers around an add/mul/div ALU
// match is combinational and only meaningful after the result load
//####################################################################
`default_nettype none

module equation_datapath (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire equation_pkg::eq_uop_t  uop,
    input  wire alarm_pkg::operand_t    data_in,
    input  wire alarm_pkg::target_t     target,
    output logic                        match
);

    alarm_pkg::operand_t x_q;
    alarm_pkg::operand_t y_q;
    alarm_pkg::operand_t z_q;
    alarm_pkg::operand_t r_q;
    alarm_pkg::target_t  target_q;

    alarm_pkg::operand_t alu_a;
    alarm_pkg::operand_t alu_b;
    alarm_pkg::operand_t alu_out;

    // register select, same for both ALU inputs
    function automatic alarm_pkg::operand_t pick(
        input equation_pkg::reg_sel_t sel,
        input alarm_pkg::operand_t    x,
        input alarm_pkg::operand_t    y,
        input alarm_pkg::operand_t    z
    );
        case (sel)
            equation_pkg::sel_x: return x;
            equation_pkg::sel_y: return y;
            equation_pkg::sel_z: return z;
            default:             return '0;
        endcase
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            x_q      <= '0;
            y_q      <= '0;
            z_q      <= '0;
            r_q      <= '0;
            target_q <= '0;
        end else if (uop.clear) begin
            // fresh attempt
            x_q      <= '0;
            y_q      <= '0;
            z_q      <= '0;
            r_q      <= '0;
            target_q <= target;
        end else begin
            if (uop.load_x) begin
                x_q <= uop.from_alu ? alu_out : data_in;
            end
            if (uop.load_y) begin
                y_q <= uop.from_alu ? alu_out : data_in;
            end
            if (uop.load_z) begin
                z_q <= data_in;
            end
            if (uop.load_r) begin
                r_q <= alu_out;
            end
        end
    end

    assign alu_a = pick(uop.sel_a, x_q, y_q, z_q);
    assign alu_b = pick(uop.sel_b, x_q, y_q, z_q);

    // results wrap to 8 bits
    always_comb begin
        case (uop.op)
            equation_pkg::alu_add: alu_out = alu_a + alu_b;
            equation_pkg::alu_mul: alu_out = alu_a * alu_b;
            equation_pkg::alu_div: alu_out = (alu_b == '0) ? '0 : alu_a / alu_b;
            default:               alu_out = '0;
        endcase
    end

    assign match = (r_q == {1'b0, target_q});   // target zero-extended

endmodule : equation_datapath

`default_nettype wire

/* verilog/equation_unit.sv */
//####################################################################
// one puzzle: x, y, z entry on go, four ALU steps, compare, verdict
// go held high stalls the unit, dropping enable aborts to wait_enable
//####################################################################
`default_nettype none

module equation_unit #(
    parameter equation_pkg::equation_kind_t KIND = equation_pkg::ratio_sum
) (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      enable,
    input  wire                      go,
    input  wire alarm_pkg::operand_t data_in,
    input  wire alarm_pkg::target_t  target,
    output logic                     solved,   // held until enable drops
    output logic                     fail      // one-cycle pulse
);

    typedef enum logic [3:0] {
        st_wait_enable = 4'd0,
        st_enter_x     = 4'd1,
        st_release_x   = 4'd2,
        st_enter_y     = 4'd3,
        st_release_y   = 4'd4,
        st_enter_z     = 4'd5,
        st_release_z   = 4'd6,
        st_step_0      = 4'd7,
        st_step_1      = 4'd8,
        st_step_2      = 4'd9,
        st_step_3      = 4'd10,
        st_compare     = 4'd11,
        st_complete    = 4'd12,
        st_retry       = 4'd13
    } unit_state_t;

    unit_state_t           state_q;
    unit_state_t           state_d;
    equation_pkg::eq_uop_t uop;
    logic                  match;

    // dst <= a op b, dst is x or y
    function automatic equation_pkg::eq_uop_t alu_step(
        input equation_pkg::reg_sel_t dst,
        input equation_pkg::reg_sel_t a,
        input equation_pkg::reg_sel_t b,
        input equation_pkg::alu_op_t  op
    );
        equation_pkg::eq_uop_t u;
        u          = equation_pkg::uop_idle;
        u.from_alu = 1'b1;
        u.load_x   = (dst == equation_pkg::sel_x);
        u.load_y   = (dst == equation_pkg::sel_y);
        u.sel_a    = a;
        u.sel_b    = b;
        u.op       = op;
        return u;
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_wait_enable;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_wait_enable: if (enable) state_d = st_enter_x;
            st_enter_x:     if (go) state_d = st_release_x;
            st_release_x:   if (!go) state_d = st_enter_y;
            st_enter_y:     if (go) state_d = st_release_y;
            st_release_y:   if (!go) state_d = st_enter_z;
            st_enter_z:     if (go) state_d = st_release_z;
            st_release_z:   if (!go) state_d = st_step_0;
            st_step_0:      state_d = st_step_1;
            st_step_1:      state_d = st_step_2;
            st_step_2:      state_d = st_step_3;
            st_step_3:      state_d = st_compare;
            st_compare:     state_d = match ? st_complete : st_retry;
            st_complete:    state_d = st_complete;   // left only via enable
            st_retry:       state_d = st_enter_x;
            default:        state_d = st_wait_enable;
        endcase
        if (!enable) begin
            state_d = st_wait_enable;
        end
    end

    always_comb begin
        uop = equation_pkg::uop_idle;
        case (state_q)
            st_wait_enable, st_retry: uop.clear = 1'b1;   // also samples target
            st_enter_x: uop.load_x = go;                 // first go cycle only
            st_enter_y: uop.load_y = go;
            st_enter_z: uop.load_z = go;
            st_step_0: begin
                if (KIND == equation_pkg::ratio_sum) begin
                    uop = alu_step(equation_pkg::sel_x, equation_pkg::sel_x,
                                   equation_pkg::sel_z, equation_pkg::alu_div);
                end else begin
                    uop = alu_step(equation_pkg::sel_y, equation_pkg::sel_x,
                                   equation_pkg::sel_y, equation_pkg::alu_mul);
                end
            end
            st_step_1: begin
                // x*x in both formulas
                uop = alu_step(equation_pkg::sel_x, equation_pkg::sel_x,
                               equation_pkg::sel_x, equation_pkg::alu_mul);
            end
            st_step_2: begin
                if (KIND == equation_pkg::ratio_sum) begin
                    uop = alu_step(equation_pkg::sel_y, equation_pkg::sel_y,
                                   equation_pkg::sel_z, equation_pkg::alu_div);
                end else begin
                    uop = alu_step(equation_pkg::sel_x, equation_pkg::sel_x,
                                   equation_pkg::sel_z, equation_pkg::alu_mul);
                end
            end
            st_step_3: begin
                uop.sel_a  = equation_pkg::sel_x;   // r <= x + y
                uop.sel_b  = equation_pkg::sel_y;
                uop.op     = equation_pkg::alu_add;
                uop.load_r = 1'b1;
            end
            default: uop = equation_pkg::uop_idle;
        endcase
    end

    assign solved = (state_q == st_complete);
    assign fail   = (state_q == st_retry);

    equation_datapath i_datapath (
        .clock   (clock),
        .arst_n  (arst_n),
        .uop     (uop),
        .data_in (data_in),
        .target  (target),
        .match   (match)
    );

endmodule : equation_unit

`default_nettype wire

/* verilog/alarm_sequencer.sv */
//####################################################################
// alarm sequencer, rings on start and enables the puzzles in order
// solved inputs are only looked at in the matching solve state
//####################################################################
`default_nettype none

module alarm_sequencer (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire                                  start,
    input  wire [alarm_pkg::num_puzzles-1:0]     solved,
    output logic [alarm_pkg::num_puzzles-1:0]    enable,
    output alarm_pkg::alarm_status_t             status
);

    alarm_pkg::seq_state_t state_q;
    alarm_pkg::seq_state_t state_d;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= alarm_pkg::seq_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            alarm_pkg::seq_idle: begin
                if (start) begin
                    state_d = alarm_pkg::seq_ringing;
                end
            end
            alarm_pkg::seq_ringing: begin
                state_d = alarm_pkg::seq_solve_ratio;   // single ring cycle
            end
            alarm_pkg::seq_solve_ratio: begin
                if (solved[0]) begin
                    state_d = alarm_pkg::seq_solve_product;
                end
            end
            alarm_pkg::seq_solve_product: begin
                if (solved[1]) begin
                    state_d = alarm_pkg::seq_awake;
                end
            end
            alarm_pkg::seq_awake: begin
                if (start) begin
                    state_d = alarm_pkg::seq_idle;   // re-arm
                end
            end
            default: begin
                state_d = alarm_pkg::seq_idle;
            end
        endcase
    end

    // puzzle order lives here and nowhere else
    assign enable[0] = (state_q == alarm_pkg::seq_solve_ratio);
    assign enable[1] = (state_q == alarm_pkg::seq_solve_product);

    always_comb begin
        status         = '0;
        status.ringing = (state_q == alarm_pkg::seq_ringing)
                      || (state_q == alarm_pkg::seq_solve_ratio)
                      || (state_q == alarm_pkg::seq_solve_product);
        status.awake   = (state_q == alarm_pkg::seq_awake);
        status.active  = enable;
    end

endmodule : alarm_sequencer

`default_nettype wire

/* verilog/alarm_puzzle_top.sv */
//####################################################################
// puzzle alarm top, one sequencer and two equation units
// go, start and fail are plain levels and pulses, no handshake
//####################################################################
`default_nettype none

module alarm_puzzle_top (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire                                  start,     // one-cycle pulse
    input  wire                                  go,        // level, one press per operand
    input  wire alarm_pkg::operand_t             data_in,
    input  wire alarm_pkg::target_t              target,    // stable during a puzzle
    output alarm_pkg::alarm_status_t             status,
    output logic [alarm_pkg::num_puzzles-1:0]    fail
);

    logic [alarm_pkg::num_puzzles-1:0] enable;
    logic [alarm_pkg::num_puzzles-1:0] solved;

    alarm_sequencer i_sequencer (
        .clock  (clock),
        .arst_n (arst_n),
        .start  (start),
        .solved (solved),
        .enable (enable),
        .status (status)
    );

    // first puzzle
    equation_unit #(
        .KIND (equation_pkg::ratio_sum)
    ) i_ratio (
        .clock   (clock),
        .arst_n  (arst_n),
        .enable  (enable[0]),
        .go      (go),
        .data_in (data_in),
        .target  (target),
        .solved  (solved[0]),
        .fail    (fail[0])
    );

    // second puzzle
    equation_unit #(
        .KIND (equation_pkg::product_sum)
    ) i_product (
        .clock   (clock),
        .arst_n  (arst_n),
        .enable  (enable[1]),
        .go      (go),
        .data_in (data_in),
        .target  (target),
        .solved  (solved[1]),
        .fail    (fail[1])
    );

endmodule : alarm_puzzle_top

`default_nettype wire

/* tests/tb_alarm_puzzle_ref.svh */
//####################################################################
// reference result and compare tasks, included inside the testbench
// all formulas wrap modulo 256, x/0 gives 0, kind 0 ratio, 1 product
//####################################################################
`ifndef TB_ALARM_PUZZLE_REF_SVH
`define TB_ALARM_PUZZLE_REF_SVH

// expected 8-bit result of one puzzle
function automatic alarm_pkg::operand_t puzzle_result(
    input logic                kind,
    input alarm_pkg::operand_t x,
    input alarm_pkg::operand_t y,
    input alarm_pkg::operand_t z
);
    int unsigned xi;
    int unsigned yi;
    int unsigned zi;
    int unsigned sum;
    xi = 32'(x);
    yi = 32'(y);
    zi = 32'(z);
    if (kind == 1'b0) begin
        // (x/z)*(x/z) + y/z, truncating
        sum = (zi == 0) ? 0 : (xi / zi) * (xi / zi) + yi / zi;
    end else begin
        sum = xi * xi * zi + xi * yi;
    end
    return sum[7:0];   // low byte is the mod 256 value
endfunction

task automatic check_status(input alarm_pkg::alarm_status_t got,
                            input alarm_pkg::alarm_status_t exp);
    if (got !== exp) begin
        $display("Fail status: got %h expected %h at %0t", got, exp, $time);
        abort_run();
    end
endtask

task automatic check_fail(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        abort_run();
    end
endtask

task automatic check_operand(input string name, input alarm_pkg::operand_t got,
                             input alarm_pkg::operand_t exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        abort_run();
    end
endtask

`endif

/* tests/tb_alarm_puzzle.sv */
//####################################################################
// two rounds of ratio then product puzzle, then re-arm to idle
// product operands are random, target is the low 7 bits of the result
//####################################################################
`default_nettype none

module tb_alarm_puzzle;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_alarm_puzzle_ref.svh"

    localparam int unsigned clk_period     = 20;
    localparam int unsigned reset_cycles   = 8;
    localparam int unsigned product_tries  = 8;    // last one is forced to match
    localparam int unsigned max_attempts   = 2 * (2 + product_tries);
    localparam int unsigned attempt_cycles = 24;   // 3 presses of up to 3 cycles, 6 to verdict
    localparam int unsigned timeout_cycles = reset_cycles + max_attempts * attempt_cycles + 64;

    logic                     clock;
    logic                     arst_n;
    logic                     start;
    logic                     go;
    alarm_pkg::operand_t      data_in;
    alarm_pkg::target_t       target;
    alarm_pkg::alarm_status_t status;
    logic [1:0]               fail;

    integer                   seed;
    int unsigned              cycles      = 0;
    int unsigned              attempts    = 0;   // issued by the stimulus
    int unsigned              verdicts    = 0;   // seen by the monitor
    int unsigned              exp_unit    = 0;
    alarm_pkg::operand_t      exp_result  = '0;
    logic                     exp_match   = 1'b0;
    alarm_pkg::seq_state_t    model_state = alarm_pkg::seq_idle;

    alarm_puzzle_top i_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .start   (start),
        .go      (go),
        .data_in (data_in),
        .target  (target),
        .status  (status),
        .fail    (fail)
    );

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic alarm_pkg::alarm_status_t expected_status(input alarm_pkg::seq_state_t s);
        alarm_pkg::alarm_status_t st;
        st         = '0;
        st.ringing = (s == alarm_pkg::seq_ringing) || (s == alarm_pkg::seq_solve_ratio)
                  || (s == alarm_pkg::seq_solve_product);
        st.awake   = (s == alarm_pkg::seq_awake);
        st.active  = {s == alarm_pkg::seq_solve_product, s == alarm_pkg::seq_solve_ratio};
        return st;
    endfunction

    function automatic alarm_pkg::target_t product_target(input alarm_pkg::operand_t x,
                                                          input alarm_pkg::operand_t y,
                                                          input alarm_pkg::operand_t z);
        alarm_pkg::operand_t r;
        r = puzzle_result(1'b1, x, y, z);
        return r[6:0];   // matches only when the result is below 128
    endfunction

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", cycles);
            abort_run();
        end
    end

    // outputs are stable on the falling edge
    always @(negedge clock) begin : monitor
        logic [1:0] unit_bit;
        logic [1:0] exp_solved;
        unit_bit   = 2'b01 << exp_unit;
        exp_solved = 2'b00;
        check_status(status, expected_status(model_state));
        if (attempts != verdicts && (fail != 2'b00 || (i_dut.solved & unit_bit) != 2'b00)) begin
            exp_solved = exp_match ? unit_bit : 2'b00;
            check_fail("fail", fail, exp_match ? 2'b00 : unit_bit);
            check_fail("solved", i_dut.solved, exp_solved);
            check_operand("result", (exp_unit == 1) ? i_dut.i_product.i_datapath.r_q
                                                    : i_dut.i_ratio.i_datapath.r_q, exp_result);
            verdicts = verdicts + 1;
        end else begin
            check_fail("fail", fail, 2'b00);   // no stray or second pulse
        end
        // state after the coming edge
        if (!arst_n) begin
            model_state = alarm_pkg::seq_idle;
        end else begin
            case (model_state)
                alarm_pkg::seq_idle:
                    if (start) model_state = alarm_pkg::seq_ringing;
                alarm_pkg::seq_ringing:
                    model_state = alarm_pkg::seq_solve_ratio;
                alarm_pkg::seq_solve_ratio:
                    if (exp_solved[0]) model_state = alarm_pkg::seq_solve_product;
                alarm_pkg::seq_solve_product:
                    if (exp_solved[1]) model_state = alarm_pkg::seq_awake;
                alarm_pkg::seq_awake:
                    if (start) model_state = alarm_pkg::seq_idle;
                default:
                    model_state = alarm_pkg::seq_idle;
            endcase
        end
    end

    task automatic pulse_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    // called on a rising edge, returns on one
    task automatic press(input alarm_pkg::operand_t value);
        int unsigned hold;
        hold    = 1 + ($unsigned($random(seed)) % 2);   // 2 cycles stalls the unit
        go      <= 1'b1;
        data_in <= value;
        repeat (hold) @(posedge clock);
        go      <= 1'b0;
        @(posedge clock);
    endtask

    task automatic draw(output alarm_pkg::operand_t x, output alarm_pkg::operand_t y,
                        output alarm_pkg::operand_t z);
        x = 8'($random(seed));
        y = 8'($random(seed));
        z = 8'($random(seed));
    endtask

    task automatic wait_active(input logic [1:0] want);
        do @(negedge clock); while (status.active != want);
    endtask

    task automatic run_attempt(input int unsigned unit, input alarm_pkg::operand_t x,
                               input alarm_pkg::operand_t y, input alarm_pkg::operand_t z,
                               input alarm_pkg::target_t next_target);
        @(posedge clock);
        exp_unit   = unit;
        exp_result = puzzle_result(unit[0], x, y, z);
        exp_match  = (exp_result == {1'b0, target});
        attempts   = attempts + 1;
        press(x);
        press(y);
        press(z);
        target <= next_target;   // latched again only on retry or in wait_enable
        // verdict state starts five edges after the z release edge
        repeat (5) @(posedge clock);
        if (verdicts == attempts) begin
            $display("verdict came before the sixth edge after z was released at %0t", $time);
            abort_run();
        end
        @(posedge clock);
        if (verdicts != attempts) begin
            $display("no verdict on the sixth edge after z was released at %0t", $time);
            abort_run();
        end
    endtask

    task automatic run_round(input int unsigned round);
        alarm_pkg::operand_t px;
        alarm_pkg::operand_t py;
        alarm_pkg::operand_t pz;
        alarm_pkg::operand_t cx;
        alarm_pkg::operand_t cy;
        alarm_pkg::operand_t cz;
        int unsigned         tries;
        tries = 0;
        draw(px, py, pz);
        @(posedge clock);
        target <= (round == 0) ? 7'd39 : 7'd23;
        pulse_start();
        wait_active(2'b01);
        if (round == 0) begin
            run_attempt(0, 8'd20, 8'd9, 8'd3, product_target(px, py, pz));
        end else begin
            run_attempt(0, 8'd9, 8'd4, 8'd0, 7'd23);   // z = 0 gives 0, wrong
            run_attempt(0, 8'd200, 8'd50, 8'd7, product_target(px, py, pz));
        end
        wait_active(2'b10);
        do begin
            cx    = px;
            cy    = py;
            cz    = pz;
            tries = tries + 1;
            if (tries + 1 >= product_tries) begin
                px = 8'd1;   // 1*1*1 + 1*1 = 2
                py = 8'd1;
                pz = 8'd1;
            end else begin
                draw(px, py, pz);
            end
            run_attempt(1, cx, cy, cz, product_target(px, py, pz));
        end while (!exp_match);
        do @(negedge clock); while (!status.awake);
    endtask

    initial begin
        seed    = 32'h0d7a_be1f;
        arst_n  = 1'b0;
        start   = 1'b0;
        go      = 1'b0;
        data_in = '0;
        target  = '0;
        repeat (reset_cycles) @(posedge clock);
        arst_n <= 1'b1;
        run_round(0);
        pulse_start();   // awake back to idle
        run_round(1);
        pulse_start();
        repeat (4) @(posedge clock);
        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_alarm_puzzle

`default_nettype wire

/* vlog.f */
+incdir+tests
verilog/alarm_pkg.sv
verilog/equation_pkg.sv
verilog/equation_datapath.sv
verilog/equation_unit.sv
verilog/alarm_sequencer.sv
verilog/alarm_puzzle_top.sv
tests/tb_alarm_puzzle.sv

/* Makefile */
# Verilator build and run for the puzzle alarm testbench

VERILATOR ?= verilator
TOP       ?= tb_alarm_puzzle
RTL_TOP   ?= alarm_puzzle_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
RTL_SRCS  ?= $(filter verilog/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
